// File: Bender.yml
package:
  name: bch_channel

sources:
  - include_dirs:
      - common
    files:
      - common/bch_pkg.sv
      - common/channel_pkg.sv
      - bch/bch_encoder.sv
      - bch/bch_divider.sv
      - src/error_injector.sv
      - src/channel_ctrl.sv
      - src/bch_channel_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_bch_channel.sv

// File: bch/bch_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module bch_divider (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::codeword_t word,
    output logic               done,
    output bch_pkg::msg_t      quotient,
    output bch_pkg::remainder_t remainder
);

    import bch_pkg::*;

    localparam int CNT_W = $clog2(`BCH_K);

    codeword_t        work;         // partial dividend
    logic [CNT_W-1:0] step;         // quotient bit being formed
    logic             busy;

    codeword_t        cur_word;
    logic [CNT_W-1:0] cur_step;
    logic             q_bit;
    codeword_t        next_word;

    // -------------------------------------------------------------------
    // one long division step
    // -------------------------------------------------------------------

    // step 0 works straight off the input so the last step lands on cycle K
    assign cur_word = start ? word : work;
    assign cur_step = start ? '0 : step;
    assign q_bit    = cur_word[`BCH_N-1-cur_step];     // leading term of this step

    assign next_word = q_bit ? cur_word ^ (codeword_t'(`BCH_GEN) << (`BCH_K-1-cur_step))
                             : cur_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= CNT_W'(1);
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == CNT_W'(`BCH_K-1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            work     <= next_word;
            quotient <= {quotient[`BCH_K-2:0], q_bit};   // msb first
        end
    end

    assign remainder = work[`BCH_N-`BCH_K-1:0];   // top K bits are cleared by now

    // a division always spans exactly K clocks
    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(start, `BCH_K));

endmodule

`default_nettype wire

// File: bch/bch_encoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module bch_encoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::msg_t      msg,
    output logic               done,
    output bch_pkg::codeword_t word
);

    import bch_pkg::*;

    // non-systematic code: c(x) = m(x) * g(x) over GF(2)
    function automatic codeword_t gf2_mul(input msg_t m);
        codeword_t acc;
        acc = '0;
        for (int i = 0; i < `BCH_K; i++) begin
            if (m[i])
                acc = acc ^ (codeword_t'(`BCH_GEN) << i);   // add shifted g(x)
        end
        return acc;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            done <= 1'b0;
        else
            done <= start;
    end

    always_ff @(posedge clk) begin
        if (start)
            word <= gf2_mul(msg);
    end

endmodule

`default_nettype wire

// File: common/bch_consts.svh
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// BCH(15,5) code able to correct up to three errors
`define BCH_N          15
`define BCH_K          5

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
`define BCH_GEN        11'b10100110111

`define BCH_MAX_ERRORS 6           // below the minimum distance of 7
`define PRNG_SEED      16'hb5e3    // any nonzero value works

`endif

// File: common/bch_pkg.sv
`default_nettype none

`include "bch_consts.svh"

package bch_pkg;

    // -------------------------------------------------------------------
    // code word shapes
    // -------------------------------------------------------------------

    // user data before encoding
    typedef logic [`BCH_K-1:0] msg_t;

    typedef logic [`BCH_N-1:0] codeword_t;    // what travels over the channel

    // left over after division by g(x), zero for a valid code word
    typedef logic [`BCH_N-`BCH_K-1:0] remainder_t;

endpackage

`default_nettype wire

// File: common/channel_pkg.sv
`default_nettype none

package channel_pkg;

    // -------------------------------------------------------------------
    // controller
    // -------------------------------------------------------------------

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_encode = 3'd1,
        st_inject = 3'd2,
        st_decode = 3'd3,
        st_done   = 3'd4     // single cycle, raises out_valid
    } chan_state_t;

    // one transfer as seen at the data_ready edge
    typedef struct packed {
        bch_pkg::msg_t msg;
        logic          encode_en;
        logic          errors_en;
        logic [7:0]    err_count;   // already clipped to the error cap
    } chan_req_t;

endpackage

`default_nettype wire

// File: sim/tb_bch_channel.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module tb_bch_channel;

    import bch_pkg::*;

    localparam int NUM_TESTS     = 18;
    localparam int VALID_TIMEOUT = 2000;   // cycles to wait for out_valid
    localparam int IDLE_WINDOW   = 8;
    localparam int BUSY_WINDOW   = 20;     // watch for stray pulses after a retrigger

    // one table row, stimulus first, then the expected results
    typedef struct packed {
        logic       rand_msg;   // take the message from the xorshift source
        logic [4:0] msg;
        logic       enc;
        logic       err;
        logic [7:0] count;
        logic       retrig;     // second data_ready edge while busy
        logic [3:0] exp_flips;
        logic       exp_det;
    } test_t;

    logic       clk;
    logic       rst;
    logic       data_ready;
    msg_t       data_in;
    logic       encode_en;
    logic       errors_en;
    logic [7:0] err_count;
    logic       out_valid;
    msg_t       data_out;
    codeword_t  word_out;
    logic       err_detected;

    test_t       tests [NUM_TESTS];
    logic [31:0] rng_state;
    int          valid_pulses;
    int          error_count;
    int          failed_tests;
    int          tests_run;
    bit          timed_out;

    bch_channel_top DUT (
        .clk          (clk),
        .rst          (rst),
        .data_ready   (data_ready),
        .data_in      (data_in),
        .encode_en    (encode_en),
        .errors_en    (errors_en),
        .err_count    (err_count),
        .out_valid    (out_valid),
        .data_out     (data_out),
        .word_out     (word_out),
        .err_detected (err_detected)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (out_valid === 1'b1)
            valid_pulses <= valid_pulses + 1;   // counted one edge after it rises
    end

    // -------------------------------------------------------------------
    // reference model
    // -------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // sum of m(x) shifted by every term of g(x)
    function automatic codeword_t gf2_product(input msg_t m);
        logic [10:0] g;
        codeword_t   p;
        g = `BCH_GEN;
        p = '0;
        for (int j = 0; j < 11; j++) begin
            if (g[j])
                p = p ^ (codeword_t'(m) << j);
        end
        return p;
    endfunction

    function automatic int popcount(input codeword_t v);
        int n;
        n = 0;
        for (int i = 0; i < `BCH_N; i++) begin
            if (v[i] === 1'b1)
                n++;
        end
        return n;
    endfunction

    task automatic set_test(input int i, input logic r, input logic [4:0] m, input logic e,
                            input logic x, input logic [7:0] c, input logic rt,
                            input logic [3:0] f, input logic d);
        tests[i].rand_msg  = r;
        tests[i].msg       = m;
        tests[i].enc       = e;
        tests[i].err       = x;
        tests[i].count     = c;
        tests[i].retrig    = rt;
        tests[i].exp_flips = f;
        tests[i].exp_det   = d;
    endtask

    task automatic load_table();
        //       idx rnd  msg       enc   err   count  retrig flips det
        set_test(0,  0, 5'b10110, 1'b1, 1'b0, 8'd0,   1'b0, 4'd0, 1'b0);
        set_test(1,  0, 5'b00001, 1'b1, 1'b0, 8'd9,   1'b0, 4'd0, 1'b0);  // count ignored
        set_test(2,  0, 5'b11111, 1'b1, 1'b0, 8'd0,   1'b0, 4'd0, 1'b0);
        set_test(3,  1, 5'b00000, 1'b1, 1'b0, 8'd0,   1'b0, 4'd0, 1'b0);
        set_test(4,  1, 5'b00000, 1'b1, 1'b1, 8'd1,   1'b0, 4'd1, 1'b1);
        set_test(5,  1, 5'b00000, 1'b1, 1'b1, 8'd2,   1'b0, 4'd2, 1'b1);
        set_test(6,  1, 5'b00000, 1'b1, 1'b1, 8'd3,   1'b0, 4'd3, 1'b1);
        set_test(7,  1, 5'b00000, 1'b1, 1'b1, 8'd4,   1'b0, 4'd4, 1'b1);
        set_test(8,  1, 5'b00000, 1'b1, 1'b1, 8'd5,   1'b0, 4'd5, 1'b1);
        set_test(9,  1, 5'b00000, 1'b1, 1'b1, 8'd6,   1'b0, 4'd6, 1'b1);
        set_test(10, 1, 5'b00000, 1'b1, 1'b1, 8'd7,   1'b0, 4'd6, 1'b1);  // saturates
        set_test(11, 0, 5'b01010, 1'b1, 1'b1, 8'd200, 1'b0, 4'd6, 1'b1);
        set_test(12, 0, 5'b10011, 1'b1, 1'b1, 8'd0,   1'b0, 4'd0, 1'b0);
        set_test(13, 1, 5'b00000, 1'b0, 1'b1, 8'd3,   1'b0, 4'd3, 1'b0);  // raw mode
        set_test(14, 0, 5'b00000, 1'b0, 1'b1, 8'd9,   1'b0, 4'd6, 1'b0);
        set_test(15, 0, 5'b11001, 1'b0, 1'b0, 8'd0,   1'b0, 4'd0, 1'b0);
        set_test(16, 1, 5'b00000, 1'b1, 1'b0, 8'd0,   1'b1, 4'd0, 1'b0);
        set_test(17, 1, 5'b00000, 1'b0, 1'b1, 8'd6,   1'b1, 4'd6, 1'b0);
    endtask

    task automatic wait_for_valid(output bit seen);
        int cycles;
        cycles = 0;
        while (out_valid !== 1'b1 && cycles < VALID_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = (out_valid === 1'b1);
    endtask

    task automatic check_outputs(input test_t t, input msg_t m);
        codeword_t ref_word;
        int        flips;
        ref_word = t.enc ? gf2_product(m) : codeword_t'(m);   // clean word before errors
        flips    = popcount(word_out ^ ref_word);
        if ((^{data_out, word_out, err_detected}) === 1'bx) begin
            $display("mismatch at %0t: unknown value on the outputs", $time);
            error_count++;
        end
        if (flips != t.exp_flips) begin
            $display("mismatch at %0t: word_out %h differs from %h in %0d bits, expected %0d",
                     $time, word_out, ref_word, flips, t.exp_flips);
            error_count++;
        end
        if (err_detected !== t.exp_det) begin
            $display("mismatch at %0t: err_detected %b, expected %b",
                     $time, err_detected, t.exp_det);
            error_count++;
        end
        if (t.enc && t.exp_flips == 0 && data_out !== m) begin
            $display("mismatch at %0t: data_out %b, expected %b", $time, data_out, m);
            error_count++;
        end
        if (!t.enc && data_out !== word_out[`BCH_K-1:0]) begin
            $display("mismatch at %0t: raw data_out %b, word_out low bits %b",
                     $time, data_out, word_out[`BCH_K-1:0]);
            error_count++;
        end
    endtask

    // -------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------

    initial begin
        test_t t;
        msg_t  m;
        bit    seen;
        int    errors_before;
        int    pulses_before;
        rst          = 1'b1;
        data_ready   = 1'b0;
        data_in      = '0;
        encode_en    = 1'b0;
        errors_en    = 1'b0;
        err_count    = 8'd0;
        rng_state    = 32'h0b655365;
        valid_pulses = 0;
        error_count  = 0;
        failed_tests = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        load_table();

        repeat (4) @(negedge clk);
        rst = 1'b0;

        // nothing may come out before the first request
        errors_before = error_count;
        for (int k = 0; k < IDLE_WINDOW; k++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("mismatch at %0t: out_valid %b before any request", $time, out_valid);
                error_count++;
            end
        end
        tests_run++;
        if (error_count != errors_before)
            failed_tests++;
        $display("idle check: %s", (error_count == errors_before) ? "ok" : "errors");

        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            t = tests[i];
            if (t.rand_msg) begin
                rng_state = xorshift32(rng_state);
                m = rng_state[4:0];
            end else begin
                m = t.msg;
            end
            errors_before = error_count;
            pulses_before = valid_pulses;
            tests_run++;

            data_in    = m;
            encode_en  = t.enc;
            errors_en  = t.err;
            err_count  = t.count;
            data_ready = 1'b1;
            @(negedge clk);
            data_ready = 1'b0;
            if (t.retrig) begin     // second edge lands while the stages run
                @(negedge clk);
                data_ready = 1'b1;
                @(negedge clk);
                data_ready = 1'b0;
            end

            wait_for_valid(seen);
            if (!seen) begin
                $display("timeout: test %0d got no out_valid within %0d cycles",
                         i, VALID_TIMEOUT);
                timed_out = 1'b1;
                failed_tests++;
            end else begin
                check_outputs(t, m);
                @(negedge clk);
                if (out_valid !== 1'b0) begin
                    $display("mismatch at %0t: out_valid high for more than one cycle", $time);
                    error_count++;
                end
                if (t.retrig) begin
                    for (int k = 0; k < BUSY_WINDOW; k++)
                        @(negedge clk);
                end
                if (valid_pulses - pulses_before != 1) begin
                    $display("mismatch at %0t: %0d out_valid pulses for one request",
                             $time, valid_pulses - pulses_before);
                    error_count++;
                end
                if (error_count != errors_before)
                    failed_tests++;
                $display("test %0d: msg %b enc %b err %b count %0d word %h: %s",
                         i, m, t.enc, t.err, t.count, word_out,
                         (error_count == errors_before) ? "ok" : "errors");
            end
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0 && !timed_out)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/bch_channel_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module bch_channel_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               data_ready,
    input  bch_pkg::msg_t      data_in,
    input  logic               encode_en,
    input  logic               errors_en,
    input  logic [7:0]         err_count,
    output logic               out_valid,
    output bch_pkg::msg_t      data_out,
    output bch_pkg::codeword_t word_out,
    output logic               err_detected
);

    import bch_pkg::*;
    import channel_pkg::*;

    chan_req_t  req;
    logic       enc_start;
    logic       enc_done;
    logic       inj_start;
    logic       inj_done;
    logic       dec_start;
    logic       dec_done;
    logic       ctrl_valid;

    codeword_t  enc_word;
    codeword_t  inj_in;
    codeword_t  inj_word;
    codeword_t  dec_word;
    codeword_t  final_word;
    msg_t       quotient;
    remainder_t remainder;

    // raw mode sends the zero-extended message
    assign inj_in     = req.encode_en ? enc_word : codeword_t'(req.msg);
    assign dec_word   = req.errors_en ? inj_word : enc_word;
    assign final_word = req.errors_en ? inj_word : inj_in;

    channel_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .data_ready (data_ready),
        .data_in    (data_in),
        .encode_en  (encode_en),
        .errors_en  (errors_en),
        .err_count  (err_count),
        .enc_done   (enc_done),
        .inj_done   (inj_done),
        .dec_done   (dec_done),
        .req        (req),
        .enc_start  (enc_start),
        .inj_start  (inj_start),
        .dec_start  (dec_start),
        .out_valid  (ctrl_valid)
    );

    bch_encoder u_enc (
        .clk   (clk),
        .rst   (rst),
        .start (enc_start),
        .msg   (req.msg),
        .done  (enc_done),
        .word  (enc_word)
    );

    error_injector u_inj (
        .clk      (clk),
        .rst      (rst),
        .start    (inj_start),
        .word_in  (inj_in),
        .count    (req.err_count),
        .done     (inj_done),
        .word_out (inj_word)
    );

    bch_divider u_dec (
        .clk       (clk),
        .rst       (rst),
        .start     (dec_start),
        .word      (dec_word),
        .done      (dec_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // -------------------------------------------------------------------
    // results, loaded together with the delayed valid
    // -------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= ctrl_valid;
    end

    always_ff @(posedge clk) begin
        if (ctrl_valid) begin
            word_out     <= final_word;
            data_out     <= req.encode_en ? quotient : final_word[`BCH_K-1:0];
            err_detected <= req.encode_en && (remainder != '0);   // no check in raw mode
        end
    end

endmodule

`default_nettype wire

// File: src/channel_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module channel_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  data_ready,
    input  bch_pkg::msg_t         data_in,
    input  logic                  encode_en,
    input  logic                  errors_en,
    input  logic [7:0]            err_count,
    input  logic                  enc_done,
    input  logic                  inj_done,
    input  logic                  dec_done,
    output channel_pkg::chan_req_t req,
    output logic                  enc_start,
    output logic                  inj_start,
    output logic                  dec_start,
    output logic                  out_valid
);

    import channel_pkg::*;

    chan_state_t state;
    chan_state_t next_state;
    logic        ready_q;
    logic        ready_rise;
    logic [7:0]  count_sat;

    assign ready_rise = data_ready && !ready_q;
    assign count_sat  = (err_count > 8'(`BCH_MAX_ERRORS)) ? 8'(`BCH_MAX_ERRORS) : err_count;

    // -------------------------------------------------------------------
    // stage sequencing
    // -------------------------------------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            st_idle:       // req is not loaded yet so steer from the inputs
                if (ready_rise)
                    next_state = encode_en ? st_encode : (errors_en ? st_inject : st_done);
            st_encode:
                if (enc_done)
                    next_state = req.errors_en ? st_inject : st_decode;
            st_inject:
                if (inj_done)
                    next_state = req.encode_en ? st_decode : st_done;
            st_decode:
                if (dec_done)
                    next_state = st_done;
            default:
                next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            ready_q   <= 1'b0;
            enc_start <= 1'b0;
            inj_start <= 1'b0;
            dec_start <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state     <= next_state;
            ready_q   <= data_ready;
            // each start fires once on entry into its stage
            enc_start <= (next_state == st_encode) && (state != st_encode);
            inj_start <= (next_state == st_inject) && (state != st_inject);
            dec_start <= (next_state == st_decode) && (state != st_decode);
            out_valid <= (next_state == st_done);
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && ready_rise)
            req <= '{msg: data_in, encode_en: encode_en, errors_en: errors_en,
                     err_count: count_sat};
    end

    // stages are started one at a time and never on two cycles in a row
    a_one_start: assert property (@(posedge clk) disable iff (rst)
        (enc_start || inj_start || dec_start) |=> !(enc_start || inj_start || dec_start));

endmodule

`default_nettype wire

// File: src/error_injector.sv
`timescale 1ns/1ns
`default_nettype none

`include "bch_consts.svh"

module error_injector (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::codeword_t word_in,
    input  logic [7:0]         count,
    output logic               done,
    output bch_pkg::codeword_t word_out
);

    import bch_pkg::*;

    logic [15:0] prng;
    logic [15:0] prng_next;
    logic [3:0]  idx;
    codeword_t   mask;          // positions flipped so far
    logic [3:0]  flipped;
    logic        busy;
    logic        hit;

    // -------------------------------------------------------------------
    // position source
    // -------------------------------------------------------------------

    // xorshift with shifts 7/9/8, period 2^16 - 1
    always_comb begin
        prng_next = prng ^ (prng << 7);
        prng_next = prng_next ^ (prng_next >> 9);
        prng_next = prng_next ^ (prng_next << 8);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            prng <= `PRNG_SEED;
        else
            prng <= prng_next;       // free running
    end

    assign idx = prng[3:0];

    // index 15 lies outside the word and is simply skipped
    assign hit = busy && (idx < `BCH_N) && !mask[idx];

    // -------------------------------------------------------------------
    // flipping
    // -------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            mask    <= '0;
            flipped <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mask    <= '0;
                flipped <= '0;
                busy    <= (count != 8'd0);
                done    <= (count == 8'd0);   // nothing to flip
            end else if (hit) begin
                mask[idx] <= 1'b1;
                flipped   <= flipped + 1'b1;
                if ({4'd0, flipped} + 8'd1 == count) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            word_out <= word_in;
        else if (hit)
            word_out[idx] <= ~word_out[idx];
    end

    // count is held by the controller for the whole run
    a_mask_bound: assert property (@(posedge clk) disable iff (rst)
        busy |-> ($countones(mask) <= count));

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/bch_pkg.sv
common/channel_pkg.sv
bch/bch_encoder.sv
bch/bch_divider.sv
src/error_injector.sv
src/channel_ctrl.sv
src/bch_channel_top.sv
sim/tb_bch_channel.sv
